/* sources.f */
+incdir+verilog
verilog/icachePkg.sv
verilog/icacheWays.sv
verilog/icacheController.sv
verilog/icacheRegs.sv
verilog/instrCache.sv
testbench/instrCacheTb.sv

/* run.sh */
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module instrCacheTb -o simv \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/simv | tee /dev/stderr | grep -q '^>>> PASS$' \
    && echo "Simulation finished without errors" \
    || { echo "Simulation reported errors"; exit 1; }

/* testbench/instrCacheTb.sv */
// Instruction cache testbench
// Clock, reset, bus memory model, fetch and register stimulus, checking assertions

`timescale 1ns/1ns
`include "icache_cfg.svh"

module instrCacheTb;

    localparam int BlockWords = `ICACHE_BLOCK_WORDS;
    localparam int Timeout    = 100;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 fetchReq;
    logic [31:0]          fetchAddr;
    logic                 fetchAck;
    icachePkg::fetchRspT  fetchRsp;
    logic                 busReq;
    icachePkg::busCmdT    busCmd;
    logic                 busAck;
    logic [31:0]          busData;
    logic                 regReq;
    icachePkg::regCmdT    regCmd;
    logic                 regAck;
    logic [31:0]          regRdata;

    // Expected values and bookkeeping
    logic        expHit;
    logic [31:0] expData;
    int          expBus;
    logic        regCheck;
    logic [31:0] regExp;
    logic        idleCheck;
    logic        bypassMode;
    int          busTotal;
    int          busStart;
    logic [31:0] busWantAddr;
    int          ackDelay;
    int          reqEdges;
    int          hitTally;
    int          missTally;
    int          seed = 32'h479d;

    instrCache DUT (
        .clk, .rstN, .fetchReq, .fetchAddr, .fetchAck, .fetchRsp,
        .busReq, .busCmd, .busAck, .busData, .regReq, .regCmd, .regAck, .regRdata
    );

    always #20 clk = ~clk;

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // Memory contents follow from the word address
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    // Bus memory, answers each request after 0 to 3 cycles
    initial begin
        busAck      = 1'b0;
        busData     = '0;
        busTotal    = 0;
        busWantAddr = '0;
        ackDelay    = $unsigned($random(seed)) % 4;
        forever begin
            @(negedge clk);
            if (busReq && !busAck) begin
                if (ackDelay > 0) begin
                    ackDelay = ackDelay - 1;
                end else begin
                    // Refill walks the block upward, bypass reads the fetch word
                    if (bypassMode) begin
                        busWantAddr = fetchAddr & ~32'd3;
                    end else begin
                        busWantAddr = (fetchAddr & ~32'(BlockWords * 4 - 1))
                                    + 32'((busTotal - busStart) * 4);
                    end
                    busData  = memWord(busCmd.addr);
                    busAck   = 1'b1;
                    busTotal = busTotal + 1;
                end
            end else if (!busReq && busAck) begin
                busAck   = 1'b0;
                ackDelay = $unsigned($random(seed)) % 4;
            end
        end
    end

    // Edges since fetchReq was first seen high
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqEdges <= 0;
        end else if (!fetchReq) begin
            reqEdges <= 0;
        end else if (!fetchAck) begin
            reqEdges <= reqEdges + 1;
        end
    end

    idleAfterReset: assert property (@(posedge clk) idleCheck |->
        !fetchAck && !busReq && !regAck)
        else stopOnError($sformatf("Mismatch fetchAck/busReq/regAck after reset: got %h %h %h",
            $sampled(fetchAck), $sampled(busReq), $sampled(regAck)));

    regDataCheck: assert property (@(posedge clk) disable iff (!rstN)
        regAck && regCheck |-> regRdata == regExp)
        else stopOnError($sformatf("Mismatch regRdata: got %h expected %h",
            $sampled(regRdata), $sampled(regExp)));

    rspDataCheck: assert property (@(posedge clk) disable iff (!rstN)
        fetchAck |-> fetchRsp.data == expData)
        else stopOnError($sformatf("Mismatch fetchRsp.data: got %h expected %h",
            $sampled(fetchRsp.data), $sampled(expData)));

    rspHitCheck: assert property (@(posedge clk) disable iff (!rstN)
        fetchAck |-> fetchRsp.hit == expHit)
        else stopOnError($sformatf("Mismatch fetchRsp.hit: got %h expected %h",
            $sampled(fetchRsp.hit), $sampled(expHit)));

    busCountCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(fetchAck) |-> busTotal - busStart == expBus)
        else stopOnError($sformatf("Mismatch bus transaction count: got %h expected %h",
            $sampled(busTotal - busStart), $sampled(expBus)));

    busAddrCheck: assert property (@(posedge clk) disable iff (!rstN)
        busReq && busAck |-> busCmd.addr == busWantAddr)
        else stopOnError($sformatf("Mismatch busCmd.addr: got %h expected %h",
            $sampled(busCmd.addr), $sampled(busWantAddr)));

    hitLatencyCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(fetchAck) && expHit |-> reqEdges == 2)
        else stopOnError($sformatf("Hit fetch raised fetchAck %0d edges after fetchReq, not 2",
            $sampled(reqEdges)));

    // One complete fetch handshake
    task automatic doFetch(input logic [31:0] addr, input logic wantHit, input int wantBus);
        int waited;
        @(negedge clk);
        expHit    = wantHit && !bypassMode;
        expData   = memWord(addr);
        expBus    = wantBus;
        busStart  = busTotal;
        fetchAddr = addr;
        fetchReq  = 1'b1;
        waited    = 0;
        while (!fetchAck) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > Timeout) begin
                stopOnError($sformatf("fetchAck never rose for address %h", addr));
            end
        end
        fetchReq = 1'b0;
        if (!bypassMode && wantHit) begin
            hitTally = hitTally + 1;
        end else if (!bypassMode) begin
            missTally = missTally + 1;
        end
        waited = 0;
        while (fetchAck) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > Timeout) begin
                stopOnError($sformatf("fetchAck never fell for address %h", addr));
            end
        end
    endtask

    // One register access, with an optional read data check
    task automatic regAccess(input logic wr, input icachePkg::regSelT sel,
                             input logic [31:0] wdata, input logic chk,
                             input logic [31:0] want, output logic [31:0] data);
        int waited;
        @(negedge clk);
        regCmd.write = wr;
        regCmd.sel   = sel;
        regCmd.wdata = wdata;
        regCmd.spare = 1'b0;
        regCheck     = chk;
        regExp       = want;
        regReq       = 1'b1;
        waited       = 0;
        while (!regAck) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > Timeout) begin
                stopOnError("regAck never rose for a register access");
            end
        end
        data   = regRdata;
        regReq = 1'b0;
        waited = 0;
        while (regAck) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > Timeout) begin
                stopOnError("regAck never fell after a register access");
            end
        end
        regCheck = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        int          polls;
        rstN       = 1'b0;
        fetchReq   = 1'b0;
        fetchAddr  = '0;
        regReq     = 1'b0;
        regCmd     = '0;
        expHit     = 1'b0;
        expData    = '0;
        expBus     = 0;
        busStart   = 0;
        regCheck   = 1'b0;
        regExp     = '0;
        idleCheck  = 1'b0;
        bypassMode = 1'b0;
        hitTally   = 0;
        missTally  = 0;
        repeat (16) @(negedge clk);
        rstN      = 1'b1;
        idleCheck = 1'b1;
        repeat (3) @(negedge clk);
        idleCheck = 1'b0;
        regAccess(1'b0, icachePkg::RegCtrl, '0, 1'b1, '0, rd);
        regAccess(1'b1, icachePkg::RegCtrl, 32'h1, 1'b0, '0, rd);

        // Miss fills the block in set 1, then every word hits
        doFetch(32'h0000_4014, 1'b0, BlockWords);
        for (int w = 0; w < BlockWords; w++) begin
            doFetch(32'h0000_4010 + 32'(w * 4), 1'b1, 0);
        end

        // Blocks A, B and C share set 0
        doFetch(32'h0000_1000, 1'b0, BlockWords);
        doFetch(32'h0000_2000, 1'b0, BlockWords);
        doFetch(32'h0000_1004, 1'b1, 0);
        doFetch(32'h0000_3000, 1'b0, BlockWords);
        doFetch(32'h0000_1008, 1'b1, 0);
        doFetch(32'h0000_2004, 1'b0, BlockWords);

        regAccess(1'b0, icachePkg::RegHits, '0, 1'b1, 32'(hitTally), rd);
        regAccess(1'b0, icachePkg::RegMisses, '0, 1'b1, 32'(missTally), rd);

        // Invalidate all, keep the cache enabled
        regAccess(1'b1, icachePkg::RegCtrl, 32'h3, 1'b0, '0, rd);
        rd    = 32'h1;
        polls = 0;
        while (rd[0]) begin
            regAccess(1'b0, icachePkg::RegStatus, '0, 1'b0, '0, rd);
            polls = polls + 1;
            if (polls > Timeout) begin
                stopOnError("STATUS stayed busy after invalidate");
            end
        end
        doFetch(32'h0000_4010, 1'b0, BlockWords);
        doFetch(32'h0000_401c, 1'b1, 0);

        regAccess(1'b0, icachePkg::RegHits, '0, 1'b1, 32'(hitTally), rd);
        regAccess(1'b0, icachePkg::RegMisses, '0, 1'b1, 32'(missTally), rd);
        regAccess(1'b1, icachePkg::RegHits, '0, 1'b0, '0, rd);
        regAccess(1'b0, icachePkg::RegHits, '0, 1'b1, '0, rd);
        regAccess(1'b1, icachePkg::RegMisses, '0, 1'b0, '0, rd);
        regAccess(1'b0, icachePkg::RegMisses, '0, 1'b1, '0, rd);

        // Disabled cache reads single words and counts nothing
        regAccess(1'b1, icachePkg::RegCtrl, '0, 1'b0, '0, rd);
        bypassMode = 1'b1;
        doFetch(32'h0000_4010, 1'b0, 1);
        doFetch(32'h0000_8008, 1'b0, 1);
        doFetch(32'h0000_100c, 1'b0, 1);
        regAccess(1'b0, icachePkg::RegHits, '0, 1'b1, '0, rd);
        regAccess(1'b0, icachePkg::RegMisses, '0, 1'b1, '0, rd);

        repeat (4) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* verilog/instrCache.sv */
// Instruction cache top level
// Register block, controller and two way storage

`timescale 1ns/1ns
`include "icache_cfg.svh"

module instrCache (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 fetchReq,
    input  logic [31:0]          fetchAddr,
    output logic                 fetchAck,
    output icachePkg::fetchRspT  fetchRsp,
    output logic                 busReq,
    output icachePkg::busCmdT    busCmd,
    input  logic                 busAck,
    input  logic [31:0]          busData,
    input  logic                 regReq,
    input  icachePkg::regCmdT    regCmd,
    output logic                 regAck,
    output logic [31:0]          regRdata
);

    logic                         cacheEnable, invalidateGo;
    logic                         hitPulse, missPulse, invalidateBusy;
    icachePkg::addrFieldsT        lookup;
    icachePkg::wayCtrlT           wayCtrl;
    logic [31:0]                  refillData, hitData;
    logic [`ICACHE_SET_BITS-1:0]  invalidateSet;
    logic                         invalidateStb, hit, hitWay, victimWay;

    icacheRegs regs (
        .clk, .rstN, .regReq, .regCmd, .regAck, .regRdata,
        .hitPulse, .missPulse, .invalidateBusy, .cacheEnable, .invalidateGo
    );

    icacheController ctrl (
        .clk, .rstN, .fetchReq, .fetchAddr, .fetchAck, .fetchRsp,
        .busReq, .busCmd, .busAck, .busData, .cacheEnable, .invalidateGo,
        .hitPulse, .missPulse, .invalidateBusy, .lookup, .wayCtrl, .refillData,
        .invalidateSet, .invalidateStb, .hit, .hitWay, .hitData, .victimWay
    );

    icacheWays ways (
        .clk, .rstN, .lookup, .wayCtrl, .refillData, .invalidateSet,
        .invalidateStb, .hit, .hitWay, .hitData, .victimWay
    );

endmodule

/* verilog/icacheRegs.sv */
// Cache register block
// Enable bit, invalidate command, hit and miss counters behind a req/ack port

`timescale 1ns/1ns

module icacheRegs (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 regReq,
    input  icachePkg::regCmdT    regCmd,
    output logic                 regAck,
    output logic [31:0]          regRdata,
    input  logic                 hitPulse,
    input  logic                 missPulse,
    input  logic                 invalidateBusy,
    output logic                 cacheEnable,
    output logic                 invalidateGo
);

    logic [31:0] hitCount;
    logic [31:0] missCount;
    logic        accept;
    logic        wrHits;
    logic        wrMisses;

    // Access is served on the edge where ack rises
    assign accept   = regReq && !regAck;
    assign wrHits   = accept && regCmd.write && regCmd.sel == icachePkg::RegHits;
    assign wrMisses = accept && regCmd.write && regCmd.sel == icachePkg::RegMisses;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regAck       <= 1'b0;
            cacheEnable  <= 1'b0;
            invalidateGo <= 1'b0;
            hitCount     <= '0;
            missCount    <= '0;
        end else begin
            invalidateGo <= 1'b0;
            if (accept) begin
                regAck <= 1'b1;
                if (regCmd.write && regCmd.sel == icachePkg::RegCtrl) begin
                    cacheEnable  <= regCmd.wdata[0];
                    invalidateGo <= regCmd.wdata[1];
                end
            end else if (regAck && !regReq) begin
                regAck <= 1'b0;
            end
            // Counters saturate, a write clears them
            if (wrHits) begin
                hitCount <= '0;
            end else if (hitPulse && hitCount != '1) begin
                hitCount <= hitCount + 1'b1;
            end
            if (wrMisses) begin
                missCount <= '0;
            end else if (missPulse && missCount != '1) begin
                missCount <= missCount + 1'b1;
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (accept) begin
            case (regCmd.sel)
                icachePkg::RegCtrl:   regRdata <= {31'd0, cacheEnable};
                icachePkg::RegHits:   regRdata <= hitCount;
                icachePkg::RegMisses: regRdata <= missCount;
                default:              regRdata <= {31'd0, invalidateBusy || invalidateGo};
            endcase
        end
    end

    ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(regAck) |-> $past(regReq));

endmodule

/* verilog/icacheController.sv */
// Instruction cache controller
// Fetch handshake, lookup, block refill and bypass bus master, invalidate sweep

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icacheController (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         fetchReq,
    input  logic [31:0]                  fetchAddr,
    output logic                         fetchAck,
    output icachePkg::fetchRspT          fetchRsp,
    output logic                         busReq,
    output icachePkg::busCmdT            busCmd,
    input  logic                         busAck,
    input  logic [31:0]                  busData,
    input  logic                         cacheEnable,
    input  logic                         invalidateGo,
    output logic                         hitPulse,
    output logic                         missPulse,
    output logic                         invalidateBusy,
    output icachePkg::addrFieldsT        lookup,
    output icachePkg::wayCtrlT           wayCtrl,
    output logic [31:0]                  refillData,
    output logic [`ICACHE_SET_BITS-1:0]  invalidateSet,
    output logic                         invalidateStb,
    input  logic                         hit,
    input  logic                         hitWay,
    input  logic [31:0]                  hitData,
    input  logic                         victimWay
);

    localparam int SetBits    = `ICACHE_SET_BITS;
    localparam int OffsetBits = `ICACHE_OFFSET_BITS;
    localparam logic [SetBits-1:0]    LastSet = SetBits'(`ICACHE_SETS - 1);
    localparam logic [OffsetBits-1:0] LastOff = OffsetBits'(`ICACHE_BLOCK_WORDS - 1);

    typedef enum logic [2:0] {
        Idle,
        Lookup,
        RefillReq,
        RefillWait,
        Deliver,
        Release,
        Bypass,
        InvSweep
    } stateT;

    stateT                 state;
    logic [OffsetBits-1:0] refillCnt;
    logic [SetBits-1:0]    sweepCnt;
    logic                  victimQ;
    logic                  invPending;
    logic [31:0]           rspData;
    logic                  refillBeat;

    // CPU holds the address for the whole fetch, refill included
    assign lookup = icachePkg::addrFieldsT'(fetchAddr);

    // One refill word accepted this cycle
    assign refillBeat = (state == RefillReq) && busAck;

    always_comb begin
        wayCtrl           = '0;
        wayCtrl.refillOff = refillCnt;
        if (refillBeat) begin
            wayCtrl.wayWe[victimQ] = 1'b1;
        end
        if (state == Lookup && hit) begin
            wayCtrl.lruUpdate = 1'b1;
            wayCtrl.lruWay    = hitWay;
        end else if (refillBeat && refillCnt == LastOff) begin
            wayCtrl.lruUpdate = 1'b1;
            wayCtrl.lruWay    = victimQ;
        end
    end

    assign refillData     = busData;
    assign hitPulse       = (state == Lookup) && hit;
    assign missPulse      = (state == Lookup) && !hit;
    assign invalidateSet  = sweepCnt;
    assign invalidateStb  = (state == InvSweep);
    assign invalidateBusy = invPending || (state == InvSweep);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= Idle;
            fetchAck   <= 1'b0;
            busReq     <= 1'b0;
            refillCnt  <= '0;
            sweepCnt   <= '0;
            victimQ    <= 1'b0;
            invPending <= 1'b0;
        end else begin
            // An invalidate during a fetch waits for the fetch to finish
            if (invalidateGo) begin
                invPending <= 1'b1;
            end
            case (state)
                Idle: begin
                    if (invPending || invalidateGo) begin
                        invPending <= 1'b0;
                        sweepCnt   <= '0;
                        state      <= InvSweep;
                    end else if (fetchReq && cacheEnable) begin
                        state <= Lookup;
                    end else if (fetchReq) begin
                        busReq <= 1'b1;
                        state  <= Bypass;
                    end
                end
                Lookup: begin
                    if (hit) begin
                        fetchAck <= 1'b1;
                        state    <= Release;
                    end else begin
                        victimQ   <= victimWay;
                        refillCnt <= '0;
                        busReq    <= 1'b1;
                        state     <= RefillReq;
                    end
                end
                RefillReq: begin
                    if (busAck) begin
                        busReq <= 1'b0;
                        state  <= RefillWait;
                    end
                end
                RefillWait: begin
                    if (!busAck) begin
                        if (refillCnt == LastOff) begin
                            state <= Deliver;
                        end else begin
                            refillCnt <= refillCnt + 1'b1;
                            busReq    <= 1'b1;
                            state     <= RefillReq;
                        end
                    end
                end
                Deliver: begin
                    fetchAck <= 1'b1;
                    state    <= Release;
                end
                Release: begin
                    if (!fetchReq) begin
                        fetchAck <= 1'b0;
                        state    <= Idle;
                    end
                end
                Bypass: begin
                    // Single word read, then wait for the bus ack to drop
                    if (busReq && busAck) begin
                        busReq <= 1'b0;
                    end else if (!busReq && !busAck) begin
                        state <= Deliver;
                    end
                end
                InvSweep: begin
                    sweepCnt <= sweepCnt + 1'b1;
                    if (sweepCnt == LastSet) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Bus address, response data and the word the CPU asked for
    always_ff @(posedge clk) begin
        if (state == Idle && fetchReq && !cacheEnable) begin
            busCmd.addr <= {fetchAddr[31:2], 2'b00};
        end else if (state == Lookup && !hit) begin
            busCmd.addr <= {lookup.tag, lookup.setIdx, {OffsetBits{1'b0}}, 2'b00};
        end else if (state == RefillWait && !busAck && refillCnt != LastOff) begin
            busCmd.addr <= {lookup.tag, lookup.setIdx, refillCnt + 1'b1, 2'b00};
        end
        if (refillBeat && refillCnt == lookup.wordOff) begin
            rspData <= busData;
        end else if (state == Bypass && busReq && busAck) begin
            rspData <= busData;
        end
        if (state == Lookup && hit) begin
            fetchRsp <= '{data: hitData, hit: 1'b1};
        end else if (state == Deliver) begin
            fetchRsp <= '{data: rspData, hit: 1'b0};
        end
    end

    busCmdStable: assert property (@(posedge clk) disable iff (!rstN)
        busReq && $past(busReq) |-> busCmd == $past(busCmd));

    sweepQuiet: assert property (@(posedge clk) disable iff (!rstN)
        state == InvSweep |-> !fetchAck && !busReq);

endmodule

/* verilog/icacheWays.sv */
// Two way tag, valid, data and LRU storage
// Registered lookup with hit detection and victim choice, refill writes

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icacheWays (
    input  logic                         clk,
    input  logic                         rstN,
    input  icachePkg::addrFieldsT        lookup,
    input  icachePkg::wayCtrlT           wayCtrl,
    input  logic [31:0]                  refillData,
    input  logic [`ICACHE_SET_BITS-1:0]  invalidateSet,
    input  logic                         invalidateStb,
    output logic                         hit,
    output logic                         hitWay,
    output logic [31:0]                  hitData,
    output logic                         victimWay
);

    localparam int Sets       = `ICACHE_SETS;
    localparam int BlockWords = `ICACHE_BLOCK_WORDS;
    localparam int OffsetBits = `ICACHE_OFFSET_BITS;
    localparam int TagBits    = `ICACHE_TAG_BITS;
    localparam logic [OffsetBits-1:0] LastOff = OffsetBits'(BlockWords - 1);

    // Storage arrays
    logic [TagBits-1:0]    tagMem  [2][Sets];
    logic [31:0]           dataMem [2][Sets][BlockWords];
    logic [Sets-1:0][1:0]  validMem;
    logic [Sets-1:0]       lruMem;

    // Registered read side
    logic [TagBits-1:0]    rdTag [2];
    logic [31:0]           rdData [2];
    logic [1:0]            rdValid;
    logic                  rdLru;
    logic [TagBits-1:0]    cmpTag;
    logic [1:0]            hitVec;

    // Tag and data writes, array reads one cycle behind the lookup
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayCtrl.wayWe[w]) begin
                dataMem[w][lookup.setIdx][wayCtrl.refillOff] <= refillData;
                tagMem[w][lookup.setIdx] <= lookup.tag;
            end
            rdTag[w]  <= tagMem[w][lookup.setIdx];
            rdData[w] <= dataMem[w][lookup.setIdx][lookup.wordOff];
        end
        cmpTag <= lookup.tag;
    end

    // Valid and LRU bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validMem <= '0;
            lruMem   <= '0;
            rdValid  <= '0;
            rdLru    <= 1'b0;
        end else begin
            rdValid <= validMem[lookup.setIdx];
            rdLru   <= lruMem[lookup.setIdx];
            if (invalidateStb) begin
                validMem[invalidateSet] <= 2'b00;
                lruMem[invalidateSet]   <= 1'b0;
            end
            for (int w = 0; w < 2; w++) begin
                // Block turns valid only once its last word lands
                if (wayCtrl.wayWe[w] && wayCtrl.refillOff == LastOff) begin
                    validMem[lookup.setIdx][w] <= 1'b1;
                end else if (wayCtrl.wayWe[w] && wayCtrl.refillOff == '0) begin
                    validMem[lookup.setIdx][w] <= 1'b0;
                end
            end
            // LRU bit names the way used least recently
            if (wayCtrl.lruUpdate) begin
                lruMem[lookup.setIdx] <= ~wayCtrl.lruWay;
            end
        end
    end

    // Tag compare on the registered read
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hitVec[w] = rdValid[w] && (rdTag[w] == cmpTag);
        end
    end

    assign hit     = |hitVec;
    assign hitWay  = hitVec[1];
    assign hitData = hitVec[1] ? rdData[1] : rdData[0];

    // Empty way first, else the least recently used one
    assign victimWay = !rdValid[0] ? 1'b0 :
                       !rdValid[1] ? 1'b1 : rdLru;

    // A block lives in at most one way of its set
    wayHitOneHot: assert property (@(posedge clk) disable iff (!rstN)
        hitVec != 2'b11);

endmodule

/* verilog/icachePkg.sv */
// Shared instruction cache types
// Address split, fetch response, bus command, register command and way control

`include "icache_cfg.svh"

package icachePkg;

    // Byte address split into cache fields
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_SET_BITS-1:0]    setIdx;
        logic [`ICACHE_OFFSET_BITS-1:0] wordOff;
        logic [1:0]                     byteOff;
    } addrFieldsT;

    // Fetch result returned with fetchAck
    typedef struct packed {
        logic [31:0] data;
        logic        hit;
    } fetchRspT;

    // Single word bus read
    typedef struct packed {
        logic [31:0] addr;
    } busCmdT;

    typedef enum logic [1:0] {
        RegCtrl   = 2'd0,
        RegHits   = 2'd1,
        RegMisses = 2'd2,
        RegStatus = 2'd3
    } regSelT;

    typedef struct packed {
        logic        write;
        regSelT      sel;
        logic [31:0] wdata;
        logic        spare;
    } regCmdT;

    // Controller to ways, refill writes and LRU updates
    typedef struct packed {
        logic [1:0]                     wayWe;
        logic [`ICACHE_OFFSET_BITS-1:0] refillOff;
        logic                           lruUpdate;
        logic                           lruWay;
    } wayCtrlT;

endpackage

/* verilog/icache_cfg.svh */
// Instruction cache geometry
// Set count, block size and the address field widths derived from them

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Number of sets, a power of two
`define ICACHE_SETS 4

// Words per block, a power of two
`define ICACHE_BLOCK_WORDS 4

// Derived address field widths
`define ICACHE_SET_BITS $clog2(`ICACHE_SETS)
`define ICACHE_OFFSET_BITS $clog2(`ICACHE_BLOCK_WORDS)

// Word address is 30 bits, the tag takes what set and offset leave
`define ICACHE_TAG_BITS (30 - `ICACHE_SET_BITS - `ICACHE_OFFSET_BITS)

`endif
